// ==== include/spw_link_defines.svh ====
// timer counts are derived from SPW_CLK_MHZ and assume it is a whole number of MHz
`ifndef SPW_LINK_DEFINES_SVH
`define SPW_LINK_DEFINES_SVH

// ---------------------------------------------------------------------------
// system clock
// ---------------------------------------------------------------------------

// i_clk rate in MHz
`define SPW_CLK_MHZ 50

// ---------------------------------------------------------------------------
// link timers
// ---------------------------------------------------------------------------

// 6.4 us after ErrorReset, in i_clk cycles
`define SPW_T6P4_CYCLES ((`SPW_CLK_MHZ * 64) / 10)
// 12.8 us ErrorWait and connect timeout, in i_clk cycles
`define SPW_T12P8_CYCLES ((`SPW_CLK_MHZ * 128) / 10)

// flops per clock-domain crossing, two or more
`define SPW_SYNC_STAGES 2

`endif

// ==== logic/spw_link_fsm.sv ====
// event inputs must already be i_clk pulses and command levels may come from any clock
`timescale 1ns/100ps

`include "spw_link_defines.svh"

module spw_link_fsm
(
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_link_start,
  input  logic                       i_link_disable,
  input  logic                       i_auto_start,
  input  logic                       i_got_null,
  input  logic                       i_got_fct,
  input  logic                       i_got_n_char,
  input  logic                       i_got_time_code,
  input  logic                       i_rx_error,
  input  logic                       i_after_6p4,
  input  logic                       i_after_12p8,
  output logic                       o_timer_6p4_reset,
  output logic                       o_timer_12p8_start,
  output logic                       o_tx_en,
  output logic                       o_rx_en,
  output logic                       o_send_nulls,
  output logic                       o_send_fcts,
  output logic                       o_send_n_chars,
  output logic                       o_send_time_codes,
  output logic                       o_char_sequence_error,
  output logic                       o_link_reset_n,
  output spw_state_pkg::link_state_t o_link_state
);

  // command synchroniser chains, msb is the safe end
  logic [`SPW_SYNC_STAGES-1:0] link_start_q;
  logic [`SPW_SYNC_STAGES-1:0] link_disable_q;
  logic [`SPW_SYNC_STAGES-1:0] auto_start_q;
  logic                        link_start;
  logic                        link_disable;
  logic                        auto_start;

  spw_state_pkg::link_state_t  state;
  spw_state_pkg::link_state_t  next_state;
  // NULL seen since the last ErrorReset
  logic                        got_null_seen;
  logic                        seq_err;
  // any character besides NULL
  logic                        got_data;

  // ---------------------------------------------------------------------------
  // command level synchronisers
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      link_start_q   <= '0;
      link_disable_q <= '0;
      auto_start_q   <= '0;
    end
    else
    begin
      link_start_q   <= {link_start_q[`SPW_SYNC_STAGES-2:0], i_link_start};
      link_disable_q <= {link_disable_q[`SPW_SYNC_STAGES-2:0], i_link_disable};
      auto_start_q   <= {auto_start_q[`SPW_SYNC_STAGES-2:0], i_auto_start};
    end
  end

  assign link_start   = link_start_q[`SPW_SYNC_STAGES-1];
  assign link_disable = link_disable_q[`SPW_SYNC_STAGES-1];
  assign auto_start   = auto_start_q[`SPW_SYNC_STAGES-1];
  assign got_data     = i_got_fct | i_got_n_char | i_got_time_code;

  // ---------------------------------------------------------------------------
  // next state, priority per state as in the link standard
  // ---------------------------------------------------------------------------
  always_comb
  begin
    next_state = state;
    seq_err    = 1'b0;
    case (state)
      spw_state_pkg::ERROR_RESET:
      begin
        // rx error keeps the link here
        if (i_after_6p4 && !i_rx_error)
          next_state = spw_state_pkg::ERROR_WAIT;
      end
      spw_state_pkg::ERROR_WAIT:
      begin
        if (i_rx_error)
          next_state = spw_state_pkg::ERROR_RESET;
        else if (got_data)
        begin
          next_state = spw_state_pkg::ERROR_RESET;
          seq_err    = 1'b1;
        end
        else if (i_after_12p8)
          next_state = spw_state_pkg::READY;
      end
      spw_state_pkg::READY:
      begin
        if (i_rx_error)
          next_state = spw_state_pkg::ERROR_RESET;
        else if (got_data)
        begin
          next_state = spw_state_pkg::ERROR_RESET;
          seq_err    = 1'b1;
        end
        // auto start needs a NULL from the far end first
        else if (link_start || (auto_start && got_null_seen))
          next_state = spw_state_pkg::STARTED;
      end
      spw_state_pkg::STARTED:
      begin
        if (i_rx_error || link_disable)
          next_state = spw_state_pkg::ERROR_RESET;
        else if (got_data)
        begin
          next_state = spw_state_pkg::ERROR_RESET;
          seq_err    = 1'b1;
        end
        else if (i_after_12p8)
          next_state = spw_state_pkg::ERROR_RESET;
        else if (i_got_null || got_null_seen)
          next_state = spw_state_pkg::CONNECTING;
      end
      spw_state_pkg::CONNECTING:
      begin
        if (i_rx_error || link_disable || i_after_12p8)
          next_state = spw_state_pkg::ERROR_RESET;
        // FCT allowed here, only N-chars and time codes are wrong
        else if (i_got_n_char || i_got_time_code)
        begin
          next_state = spw_state_pkg::ERROR_RESET;
          seq_err    = 1'b1;
        end
        else if (i_got_fct)
          next_state = spw_state_pkg::RUN;
      end
      spw_state_pkg::RUN:
      begin
        if (i_rx_error || link_disable)
          next_state = spw_state_pkg::ERROR_RESET;
      end
      default:
        next_state = spw_state_pkg::ERROR_RESET;
    endcase
  end

  // ---------------------------------------------------------------------------
  // state register and outputs, decoded from next state
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      state                 <= spw_state_pkg::ERROR_RESET;
      got_null_seen         <= 1'b0;
      o_timer_6p4_reset     <= 1'b1;
      o_timer_12p8_start    <= 1'b0;
      o_tx_en               <= 1'b0;
      o_rx_en               <= 1'b0;
      o_send_nulls          <= 1'b0;
      o_send_fcts           <= 1'b0;
      o_send_n_chars        <= 1'b0;
      o_send_time_codes     <= 1'b0;
      o_char_sequence_error <= 1'b0;
      o_link_reset_n        <= 1'b0;
    end
    else
    begin
      state <= next_state;
      // remembered through ErrorWait, Ready and Started
      if (state == spw_state_pkg::ERROR_RESET)
        got_null_seen <= 1'b0;
      else if (i_got_null && (state inside {spw_state_pkg::ERROR_WAIT, spw_state_pkg::READY}))
        got_null_seen <= 1'b1;
      // 6.4 us count runs only while resting in ErrorReset
      o_timer_6p4_reset <= (state != spw_state_pkg::ERROR_RESET) ||
                           (next_state != spw_state_pkg::ERROR_RESET);
      // one pulse on entry to each timed state
      o_timer_12p8_start <= (next_state != state) &&
                            (next_state inside {spw_state_pkg::ERROR_WAIT,
                                                spw_state_pkg::STARTED,
                                                spw_state_pkg::CONNECTING});
      o_rx_en           <= (next_state != spw_state_pkg::ERROR_RESET);
      o_link_reset_n    <= (next_state != spw_state_pkg::ERROR_RESET);
      o_tx_en           <= next_state inside {spw_state_pkg::STARTED,
                                              spw_state_pkg::CONNECTING, spw_state_pkg::RUN};
      o_send_nulls      <= next_state inside {spw_state_pkg::STARTED,
                                              spw_state_pkg::CONNECTING, spw_state_pkg::RUN};
      o_send_fcts       <= next_state inside {spw_state_pkg::CONNECTING, spw_state_pkg::RUN};
      o_send_n_chars    <= (next_state == spw_state_pkg::RUN);
      o_send_time_codes <= (next_state == spw_state_pkg::RUN);
      // high in the first ErrorReset cycle only
      o_char_sequence_error <= seq_err;
    end
  end

  assign o_link_state = state;

endmodule

// ==== logic/spw_link_timers.sv ====
// counts assume i_clk runs at SPW_CLK_MHZ and the 12.8 us start is a one-cycle pulse
`timescale 1ns/100ps

`include "spw_link_defines.svh"

module spw_link_timers
(
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_timer_6p4_reset,
  input  logic i_timer_12p8_start,
  output logic o_after_6p4,
  output logic o_after_12p8
);

  // last count before the 6.4 us flag rises
  localparam spw_timing_pkg::tick_count_t T6P4_LAST =
    spw_timing_pkg::tick_count_t'(`SPW_T6P4_CYCLES - 1);
  // start cycle itself counts as one, hence minus two
  localparam spw_timing_pkg::tick_count_t T12P8_LAST =
    spw_timing_pkg::tick_count_t'(`SPW_T12P8_CYCLES - 2);

  spw_timing_pkg::tick_count_t cnt_6p4;
  spw_timing_pkg::tick_count_t cnt_12p8;
  logic                        armed_12p8;

  // ---------------------------------------------------------------------------
  // 6.4 us timer, level reset, saturating
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      cnt_6p4     <= '0;
      o_after_6p4 <= 1'b0;
    end
    else if (i_timer_6p4_reset)
    begin
      cnt_6p4     <= '0;
      o_after_6p4 <= 1'b0;
    end
    else if (cnt_6p4 == T6P4_LAST)
      // hold here until the next reset
      o_after_6p4 <= 1'b1;
    else
      cnt_6p4 <= cnt_6p4 + 1'b1;
  end

  // ---------------------------------------------------------------------------
  // 12.8 us timer, one shot per start pulse
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      cnt_12p8     <= '0;
      armed_12p8   <= 1'b0;
      o_after_12p8 <= 1'b0;
    end
    else
    begin
      // pulse output, low unless the count ends this cycle
      o_after_12p8 <= 1'b0;
      if (i_timer_12p8_start)
      begin
        // restart also cancels a pending expiry
        cnt_12p8   <= '0;
        armed_12p8 <= 1'b1;
      end
      else if (armed_12p8)
      begin
        if (cnt_12p8 == T12P8_LAST)
        begin
          o_after_12p8 <= 1'b1;
          armed_12p8   <= 1'b0;
        end
        else
          cnt_12p8 <= cnt_12p8 + 1'b1;
      end
    end
  end

endmodule

// ==== logic/spw_link_top.sv ====
// receiver event pulses must be single-cycle on i_rx_clk and four i_clk cycles apart
`timescale 1ns/100ps

module spw_link_top
(
  input  logic                       i_clk,
  input  logic                       i_rx_clk,
  input  logic                       i_reset_n,
  input  logic                       i_link_start,
  input  logic                       i_link_disable,
  input  logic                       i_auto_start,
  input  logic                       i_got_null,
  input  logic                       i_got_fct,
  input  logic                       i_got_n_char,
  input  logic                       i_got_time_code,
  input  logic                       i_rx_error,
  output logic                       o_tx_en,
  output logic                       o_rx_en,
  output logic                       o_send_nulls,
  output logic                       o_send_fcts,
  output logic                       o_send_n_chars,
  output logic                       o_send_time_codes,
  output logic                       o_char_sequence_error,
  output logic                       o_link_reset_n,
  output spw_state_pkg::link_state_t o_link_state
);

  // ---------------------------------------------------------------------------
  // receiver events into the i_clk domain
  // ---------------------------------------------------------------------------

  // index order null, fct, n-char, time code, rx error
  logic [4:0] rx_events;
  logic [4:0] clk_events;
  logic       timer_6p4_reset;
  logic       timer_12p8_start;
  logic       after_6p4;
  logic       after_12p8;

  assign rx_events = {i_rx_error, i_got_time_code, i_got_n_char, i_got_fct, i_got_null};

  for (genvar i = 0; i < 5; i++)
  begin : g_event_sync
    spw_pulse_sync u_sync
    (
      .i_clk     (i_clk),
      .i_rx_clk  (i_rx_clk),
      .i_reset_n (i_reset_n),
      .i_pulse   (rx_events[i]),
      .o_pulse   (clk_events[i])
    );
  end

  // ---------------------------------------------------------------------------
  // timers and link fsm
  // ---------------------------------------------------------------------------
  spw_link_timers u_timers
  (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_timer_6p4_reset  (timer_6p4_reset),
    .i_timer_12p8_start (timer_12p8_start),
    .o_after_6p4        (after_6p4),
    .o_after_12p8       (after_12p8)
  );

  spw_link_fsm u_fsm
  (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_link_start          (i_link_start),
    .i_link_disable        (i_link_disable),
    .i_auto_start          (i_auto_start),
    .i_got_null            (clk_events[0]),
    .i_got_fct             (clk_events[1]),
    .i_got_n_char          (clk_events[2]),
    .i_got_time_code       (clk_events[3]),
    .i_rx_error            (clk_events[4]),
    .i_after_6p4           (after_6p4),
    .i_after_12p8          (after_12p8),
    .o_timer_6p4_reset     (timer_6p4_reset),
    .o_timer_12p8_start    (timer_12p8_start),
    .o_tx_en               (o_tx_en),
    .o_rx_en               (o_rx_en),
    .o_send_nulls          (o_send_nulls),
    .o_send_fcts           (o_send_fcts),
    .o_send_n_chars        (o_send_n_chars),
    .o_send_time_codes     (o_send_time_codes),
    .o_char_sequence_error (o_char_sequence_error),
    .o_link_reset_n        (o_link_reset_n),
    .o_link_state          (o_link_state)
  );

endmodule

// ==== logic/spw_pulse_sync.sv ====
// source pulses must be single-cycle and at least four i_clk cycles apart
`timescale 1ns/100ps

`include "spw_link_defines.svh"

module spw_pulse_sync
(
  input  logic i_clk,
  input  logic i_rx_clk,
  input  logic i_reset_n,
  input  logic i_pulse,
  output logic o_pulse
);

  // toggle in rx domain, flips once per event
  logic                        rx_toggle;
  // toggle resynchronised into i_clk domain
  logic [`SPW_SYNC_STAGES-1:0] sync_q;
  // one stage past the synchroniser for edge detect
  logic                        sync_last;

  always_ff @(posedge i_rx_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
      rx_toggle <= 1'b0;
    else
      rx_toggle <= rx_toggle ^ i_pulse;
  end

  // each toggle change becomes one o_pulse cycle
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      sync_q    <= '0;
      sync_last <= 1'b0;
      o_pulse   <= 1'b0;
    end
    else
    begin
      sync_q    <= {sync_q[`SPW_SYNC_STAGES-2:0], rx_toggle};
      sync_last <= sync_q[`SPW_SYNC_STAGES-1];
      o_pulse   <= sync_q[`SPW_SYNC_STAGES-1] ^ sync_last;
    end
  end

endmodule

// ==== logic/spw_state_pkg.sv ====
// state codes are fixed and observed by software, so keep ERROR_RESET at zero
package spw_state_pkg;

  // -------------------------------------------------------------------------
  // link state machine encoding
  // -------------------------------------------------------------------------

  // order follows the bring-up sequence of the link
  typedef enum logic [2:0]
  {
    ERROR_RESET = 3'd0,
    ERROR_WAIT  = 3'd1,
    READY       = 3'd2,
    STARTED     = 3'd3,
    CONNECTING  = 3'd4,
    RUN         = 3'd5
  } link_state_t;

  // codes 6 and 7 unused, fsm falls back to ERROR_RESET

endpackage

// ==== logic/spw_timing_pkg.sv ====
// counter width follows SPW_T12P8_CYCLES, so a faster clock widens every timer
package spw_timing_pkg;

`include "spw_link_defines.svh"

  // -------------------------------------------------------------------------
  // timer widths
  // -------------------------------------------------------------------------

  // enough bits to hold the longest count, 12.8 us
  localparam int unsigned TICK_W = $clog2(`SPW_T12P8_CYCLES + 1);

  // i_clk cycle count for both link timers
  typedef logic [TICK_W-1:0] tick_count_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f spw_link.f --top-module tb_spw_link_top \
    -o tb_spw_link_top \
  && ./obj_dir/tb_spw_link_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== spw_link.f ====
+incdir+include
logic/spw_state_pkg.sv
logic/spw_timing_pkg.sv
logic/spw_pulse_sync.sv
logic/spw_link_timers.sv
logic/spw_link_fsm.sv
logic/spw_link_top.sv
tb/tb_spw_link_top.sv

// ==== tb/tb_spw_link_top.sv ====
// timing windows assume the shipped defines with i_clk at 20 ns and i_rx_clk at 30 ns
`timescale 1ns/100ps

`include "spw_link_defines.svh"

module tb_spw_link_top;

  // event masks in {rx_error, time_code, n_char, fct, null} order
  localparam logic [4:0] EV_NULL  = 5'b00001;
  localparam logic [4:0] EV_FCT   = 5'b00010;
  localparam logic [4:0] EV_RXERR = 5'b10000;

  localparam spw_timing_pkg::tick_count_t T6P4 =
    spw_timing_pkg::tick_count_t'(`SPW_T6P4_CYCLES);
  localparam spw_timing_pkg::tick_count_t T12P8 =
    spw_timing_pkg::tick_count_t'(`SPW_T12P8_CYCLES);
  // longest wait for any state change
  localparam spw_timing_pkg::tick_count_t WAIT_LIMIT =
    spw_timing_pkg::tick_count_t'(`SPW_T12P8_CYCLES + 64);

  logic i_clk = 1'b0;
  logic i_rx_clk = 1'b0;
  logic i_reset_n;
  logic i_link_start;
  logic i_link_disable;
  logic i_auto_start;
  logic i_got_null;
  logic i_got_fct;
  logic i_got_n_char;
  logic i_got_time_code;
  logic i_rx_error;
  logic o_tx_en;
  logic o_rx_en;
  logic o_send_nulls;
  logic o_send_fcts;
  logic o_send_n_chars;
  logic o_send_time_codes;
  logic o_char_sequence_error;
  logic o_link_reset_n;
  spw_state_pkg::link_state_t o_link_state;

  logic [15:0] lfsr_q;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  // cycles seen with o_char_sequence_error high
  int          seq_err_pulses = 0;

  // 20 ns system clock and 30 ns receive clock whose rising edges never meet
  always #10 i_clk = ~i_clk;
  always #15 i_rx_clk = ~i_rx_clk;

  always @(negedge i_clk)
  begin
    if (o_char_sequence_error)
      seq_err_pulses <= seq_err_pulses + 1;
  end

  spw_link_top dut
  (
    .i_clk                 (i_clk),
    .i_rx_clk              (i_rx_clk),
    .i_reset_n             (i_reset_n),
    .i_link_start          (i_link_start),
    .i_link_disable        (i_link_disable),
    .i_auto_start          (i_auto_start),
    .i_got_null            (i_got_null),
    .i_got_fct             (i_got_fct),
    .i_got_n_char          (i_got_n_char),
    .i_got_time_code       (i_got_time_code),
    .i_rx_error            (i_rx_error),
    .o_tx_en               (o_tx_en),
    .o_rx_en               (o_rx_en),
    .o_send_nulls          (o_send_nulls),
    .o_send_fcts           (o_send_fcts),
    .o_send_n_chars        (o_send_n_chars),
    .o_send_time_codes     (o_send_time_codes),
    .o_char_sequence_error (o_char_sequence_error),
    .o_link_reset_n        (o_link_reset_n),
    .o_link_state          (o_link_state)
  );

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------

  // 16-bit Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] cur);
    logic [15:0] shifted;
    shifted = cur >> 1;
    if (cur[0])
      shifted = shifted ^ 16'hB400;
    return shifted;
  endfunction

  // 4 to 19 idle cycles from four lfsr bits
  function automatic int unsigned next_gap();
    int unsigned gap;
    gap = 0;
    for (int i = 0; i < 4; i++)
    begin
      gap    = (gap << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
    return gap + 4;
  endfunction

  // one rx clock wide pulse after a random idle gap
  task automatic send_event(input logic [4:0] mask);
    repeat (next_gap()) @(posedge i_clk);
    @(posedge i_rx_clk);
    {i_rx_error, i_got_time_code, i_got_n_char, i_got_fct, i_got_null} <= mask;
    @(posedge i_rx_clk);
    {i_rx_error, i_got_time_code, i_got_n_char, i_got_fct, i_got_null} <= 5'b00000;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("Fail %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  // expected flags follow the per-state output rule
  task automatic expect_flags(input spw_state_pkg::link_state_t st);
    logic active;
    logic sending;
    logic fcts;
    logic run;
    active  = (st != spw_state_pkg::ERROR_RESET);
    sending = (st == spw_state_pkg::STARTED) || (st == spw_state_pkg::CONNECTING) ||
              (st == spw_state_pkg::RUN);
    fcts    = (st == spw_state_pkg::CONNECTING) || (st == spw_state_pkg::RUN);
    run     = (st == spw_state_pkg::RUN);
    compare_value("o_link_state", o_link_state, st);
    compare_value("o_rx_en", o_rx_en, active);
    compare_value("o_link_reset_n", o_link_reset_n, active);
    compare_value("o_tx_en", o_tx_en, sending);
    compare_value("o_send_nulls", o_send_nulls, sending);
    compare_value("o_send_fcts", o_send_fcts, fcts);
    compare_value("o_send_n_chars", o_send_n_chars, run);
    compare_value("o_send_time_codes", o_send_time_codes, run);
  endtask

  // commands idle and reset held 8 cycles with outputs checked
  task automatic apply_reset();
    @(posedge i_clk);
    i_reset_n      <= 1'b0;
    i_link_start   <= 1'b0;
    i_link_disable <= 1'b0;
    i_auto_start   <= 1'b0;
    repeat (8)
    begin
      @(negedge i_clk);
      expect_flags(spw_state_pkg::ERROR_RESET);
      compare_value("o_char_sequence_error", o_char_sequence_error, 1'b0);
    end
    @(posedge i_clk);
    i_reset_n <= 1'b1;
  endtask

  // returns at the first negedge showing target with cycles counted from the call
  task automatic wait_state(input spw_state_pkg::link_state_t target,
                            output spw_timing_pkg::tick_count_t cycles, output bit ok);
    cycles = '0;
    ok     = 1'b0;
    while (!ok && (cycles < WAIT_LIMIT))
    begin
      @(negedge i_clk);
      if (o_link_state == target)
        ok = 1'b1;
      else
        cycles = cycles + 1'b1;
    end
    if (!ok)
    begin
      error_count++;
      $display("timeout: link did not reach %s within %0d cycles", target.name(),
               WAIT_LIMIT);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // auto start plus far-end NULL and FCT ending in Run
  task automatic bring_up_to_run(output bit ok);
    spw_timing_pkg::tick_count_t cycles;
    apply_reset();
    @(posedge i_clk);
    i_auto_start <= 1'b1;
    wait_state(spw_state_pkg::ERROR_WAIT, cycles, ok);
    if (!ok)
      return;
    // NULL lands well inside ErrorWait
    send_event(EV_NULL);
    wait_state(spw_state_pkg::STARTED, cycles, ok);
    if (!ok)
      return;
    expect_flags(spw_state_pkg::STARTED);
    wait_state(spw_state_pkg::CONNECTING, cycles, ok);
    if (!ok)
      return;
    expect_flags(spw_state_pkg::CONNECTING);
    send_event(EV_FCT);
    wait_state(spw_state_pkg::RUN, cycles, ok);
    if (ok)
      expect_flags(spw_state_pkg::RUN);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic run_reset_sequence();
    int                          errs;
    spw_timing_pkg::tick_count_t cycles;
    bit                          ok;
    errs = error_count;
    apply_reset();
    // still in ErrorReset right after release
    repeat (4)
    begin
      @(negedge i_clk);
      expect_flags(spw_state_pkg::ERROR_RESET);
      compare_value("o_char_sequence_error", o_char_sequence_error, 1'b0);
    end
    wait_state(spw_state_pkg::ERROR_WAIT, cycles, ok);
    if (ok)
    begin
      cycles = cycles + 3'd4;
      if ((cycles < T6P4) || (cycles > T6P4 + 6))
      begin
        error_count++;
        $display("ErrorWait entered %0d cycles after reset, expected %0d to %0d",
                 cycles, T6P4, T6P4 + 6);
      end
      expect_flags(spw_state_pkg::ERROR_WAIT);
    end
    report_test("1 reset and ErrorWait", errs);
  endtask

  task automatic ready_timeout();
    int                          errs;
    spw_timing_pkg::tick_count_t cycles;
    bit                          ok;
    errs = error_count;
    apply_reset();
    wait_state(spw_state_pkg::ERROR_WAIT, cycles, ok);
    if (ok)
      wait_state(spw_state_pkg::READY, cycles, ok);
    if (!ok)
    begin
      report_test("2 Ready and timeout", errs);
      return;
    end
    if ((cycles + 2 < T12P8) || (cycles > T12P8 + 6))
    begin
      error_count++;
      $display("Ready reached %0d cycles after ErrorWait, expected about %0d", cycles, T12P8);
    end
    expect_flags(spw_state_pkg::READY);
    @(posedge i_clk);
    i_link_start <= 1'b1;
    wait_state(spw_state_pkg::STARTED, cycles, ok);
    if (ok)
    begin
      expect_flags(spw_state_pkg::STARTED);
      // connect timer expires since no NULL arrives
      wait_state(spw_state_pkg::ERROR_RESET, cycles, ok);
    end
    if (ok)
    begin
      if ((cycles + 2 < T12P8) || (cycles > T12P8 + 8))
      begin
        error_count++;
        $display("Started timed out after %0d cycles, expected about %0d", cycles, T12P8);
      end
      expect_flags(spw_state_pkg::ERROR_RESET);
      compare_value("o_char_sequence_error", o_char_sequence_error, 1'b0);
    end
    @(posedge i_clk);
    i_link_start <= 1'b0;
    report_test("2 Ready and timeout", errs);
  endtask

  task automatic auto_start_bring_up();
    int errs;
    bit ok;
    errs = error_count;
    bring_up_to_run(ok);
    report_test("3 auto-start bring-up", errs);
  endtask

  task automatic sequence_error_in_ready();
    int                          errs;
    int                          pulses_before;
    spw_timing_pkg::tick_count_t cycles;
    bit                          ok;
    errs = error_count;
    apply_reset();
    wait_state(spw_state_pkg::ERROR_WAIT, cycles, ok);
    if (ok)
      wait_state(spw_state_pkg::READY, cycles, ok);
    if (ok)
    begin
      expect_flags(spw_state_pkg::READY);
      pulses_before = seq_err_pulses;
      // FCT before any link start is out of sequence
      send_event(EV_FCT);
      wait_state(spw_state_pkg::ERROR_RESET, cycles, ok);
      if (ok)
      begin
        expect_flags(spw_state_pkg::ERROR_RESET);
        compare_value("o_char_sequence_error", o_char_sequence_error, 1'b1);
        @(negedge i_clk);
        compare_value("o_char_sequence_error", o_char_sequence_error, 1'b0);
        @(posedge i_clk);
        compare_value("sequence error cycles", seq_err_pulses - pulses_before, 1);
      end
    end
    report_test("4 sequence error", errs);
  endtask

  task automatic leave_run();
    int                          errs;
    int                          pulses_before;
    spw_timing_pkg::tick_count_t cycles;
    bit                          ok;
    errs = error_count;
    // receive error ends the run
    bring_up_to_run(ok);
    if (ok)
    begin
      pulses_before = seq_err_pulses;
      send_event(EV_RXERR);
      wait_state(spw_state_pkg::ERROR_RESET, cycles, ok);
      if (ok)
      begin
        expect_flags(spw_state_pkg::ERROR_RESET);
        @(posedge i_clk);
        compare_value("sequence error cycles", seq_err_pulses - pulses_before, 0);
      end
    end
    // link disable ends the run
    bring_up_to_run(ok);
    if (ok)
    begin
      pulses_before = seq_err_pulses;
      @(posedge i_clk);
      i_link_disable <= 1'b1;
      wait_state(spw_state_pkg::ERROR_RESET, cycles, ok);
      if (ok)
        expect_flags(spw_state_pkg::ERROR_RESET);
      @(posedge i_clk);
      if (ok)
        compare_value("sequence error cycles", seq_err_pulses - pulses_before, 0);
      i_link_disable <= 1'b0;
    end
    report_test("5 leaving Run", errs);
  endtask

  // --------------------------------------------------------------------------
  // test sequence and summary
  // --------------------------------------------------------------------------
  initial
  begin
    i_reset_n       = 1'b0;
    i_link_start    = 1'b0;
    i_link_disable  = 1'b0;
    i_auto_start    = 1'b0;
    i_got_null      = 1'b0;
    i_got_fct       = 1'b0;
    i_got_n_char    = 1'b0;
    i_got_time_code = 1'b0;
    i_rx_error      = 1'b0;
    lfsr_q          = 16'd49;
    error_count     = 0;
    tests_run       = 0;
    tests_failed    = 0;

    run_reset_sequence();
    ready_timeout();
    auto_start_bring_up();
    sequence_error_in_ready();
    leave_run();

    $display("summary: %0d tests run, %0d failed, %0d check errors", tests_run,
             tests_failed, error_count);
    if (error_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule
